/* compile.f */
src/nes_frontend_pkg.sv
src/settings_regs.sv
src/pad_router.sv
src/lightgun_aim.sv
src/video_conditioner.sv
src/nes_frontend_top.sv
testbench/nes_frontend_props.sv
testbench/tb_nes_frontend.sv

/* src/lightgun_aim.sv */
// crosshair position driven by the player 1 d-pad
// one saturating step per frame at the configured speed

`default_nettype none

module lightgun_aim (
  input  wire                              clk_74a,
  input  wire                              pll_core_locked,
  input  wire                              frame_start,
  input  wire nes_frontend_pkg::nes_buttons_t  pad,
  input  wire nes_frontend_pkg::nes_settings_t settings,
  output nes_frontend_pkg::gun_aim_t       gun_aim
);

  import nes_frontend_pkg::*;

  // one axis step, clamped to 0 and 255
  // opposite directions together cancel
  function automatic aim_coord_t step_axis(
    input aim_coord_t pos,
    input aim_speed_t speed,
    input logic       inc,
    input logic       dec
  );
    logic [8:0] sum;
    aim_coord_t result;

    sum    = {1'b0, pos} + {1'b0, speed};
    result = pos;
    if (inc && !dec) begin
      result = sum[8] ? '1 : sum[7:0];
    end else if (dec && !inc) begin
      result = (pos < speed) ? '0 : pos - speed;
    end
    return result;
  endfunction

  //////////////////////////////////////////////////
  // position registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      gun_aim.x <= AIM_CENTER;
      gun_aim.y <= AIM_CENTER;
    end else if (frame_start && settings.lightgun_enabled) begin
      // screen y grows downward
      gun_aim.x <= step_axis(gun_aim.x, settings.aim_speed, pad.right, pad.left);
      gun_aim.y <= step_axis(gun_aim.y, settings.aim_speed, pad.down, pad.up);
    end
  end

endmodule

`default_nettype wire

/* src/nes_frontend_pkg.sv */
// shared definitions for the nes front end
// bridge address map, key bitmap positions, timing constants
// vector typedefs and packed structs for settings, pads and video

`default_nettype none

package nes_frontend_pkg;

  //////////////////////////////////////////////////
  // widths and vector types

  localparam int BRIDGE_ADDR_W = 32;
  localparam int BRIDGE_DATA_W = 32;

  typedef logic [BRIDGE_ADDR_W-1:0] bridge_addr_t;
  typedef logic [BRIDGE_DATA_W-1:0] bridge_data_t;
  typedef logic [15:0]              key_bitmap_t;
  // red in the high byte
  typedef logic [23:0]              rgb_t;
  typedef logic [7:0]               aim_coord_t;
  typedef logic [7:0]               aim_speed_t;
  typedef logic [2:0]               palette_sel_t;
  typedef logic [1:0]               edge_mask_t;

  //////////////////////////////////////////////////
  // bridge address map

  localparam bridge_addr_t ADDR_RESET         = 32'h050;
  localparam bridge_addr_t ADDR_HIDE_OVERSCAN = 32'h200;
  localparam bridge_addr_t ADDR_MASK_EDGES    = 32'h204;
  localparam bridge_addr_t ADDR_EXTRA_SPRITES = 32'h208;
  localparam bridge_addr_t ADDR_PALETTE       = 32'h20C;
  localparam bridge_addr_t ADDR_MULTITAP      = 32'h300;
  localparam bridge_addr_t ADDR_LIGHTGUN      = 32'h304;
  localparam bridge_addr_t ADDR_AIM_SPEED     = 32'h308;
  localparam bridge_addr_t ADDR_SWAP          = 32'h30C;

  // core reset hold, shortened for simulation
  localparam int RESET_HOLD_CYCLES = 64;
  localparam int RESET_CNT_W       = $clog2(RESET_HOLD_CYCLES + 1);

  // positions in the incoming key bitmap
  localparam int KEY_UP     = 0;
  localparam int KEY_DOWN   = 1;
  localparam int KEY_LEFT   = 2;
  localparam int KEY_RIGHT  = 3;
  localparam int KEY_A      = 4;
  localparam int KEY_B      = 5;
  localparam int KEY_SELECT = 14;
  localparam int KEY_START  = 15;

  localparam int NUM_PLAYERS = 4;

  // hsync is pushed back so it never lands on the vsync cycle
  localparam int HS_DELAY_CYCLES   = 7;
  localparam int HS_CNT_W          = $clog2(HS_DELAY_CYCLES + 1);
  localparam int SLOT_OVERSCAN_BIT = 13;

  localparam aim_coord_t AIM_CENTER = 8'd128;

  //////////////////////////////////////////////////
  // grouped signals

  typedef struct packed {
    logic         hide_overscan;
    edge_mask_t   mask_vid_edges;
    logic         allow_extra_sprites;
    palette_sel_t selected_palette;
    logic         multitap_enabled;
    logic         lightgun_enabled;
    aim_speed_t   aim_speed;
    logic         swap_controllers;
  } nes_settings_t;

  // nes shift order, a in bit 0
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } nes_buttons_t;

  typedef struct packed {
    nes_buttons_t port4;
    nes_buttons_t port3;
    nes_buttons_t port2;
    nes_buttons_t port1;
  } nes_ports_t;

  typedef struct packed {
    logic h_blank;
    logic v_blank;
    logic hs;
    logic vs;
    rgb_t rgb;
  } core_video_t;

  typedef struct packed {
    logic de;
    logic hs;
    logic vs;
    rgb_t rgb;
  } scaler_video_t;

  typedef struct packed {
    aim_coord_t x;
    aim_coord_t y;
  } gun_aim_t;

endpackage

`default_nettype wire

/* src/nes_frontend_top.sv */
// top level of the nes front end
// settings registers, pad router, lightgun aim, video conditioner

`default_nettype none

module nes_frontend_top (
  input  wire                                 clk_74a,
  input  wire                                 pll_core_locked,

  // bridge writes, no flow control
  input  wire                                 bridge_wr,
  input  wire nes_frontend_pkg::bridge_addr_t bridge_addr,
  input  wire nes_frontend_pkg::bridge_data_t bridge_wr_data,

  // controllers, player 1 at index 0
  input  wire nes_frontend_pkg::key_bitmap_t [nes_frontend_pkg::NUM_PLAYERS-1:0] cont_key,

  // core video, one sample per clock
  input  wire nes_frontend_pkg::core_video_t  core_video,

  output wire nes_frontend_pkg::nes_settings_t settings,
  output wire                                 external_reset,
  output wire nes_frontend_pkg::nes_ports_t   pads,
  output wire nes_frontend_pkg::gun_aim_t     gun_aim,
  output wire nes_frontend_pkg::scaler_video_t scaler_video
);

  //////////////////////////////////////////////////
  // control path

  settings_regs u_settings_regs (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .settings       (settings),
    .external_reset (external_reset)
  );

  pad_router u_pad_router (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .cont_key       (cont_key),
    .settings       (settings),
    .pads           (pads)
  );

  // aim steps on each scaler vsync pulse
  lightgun_aim u_lightgun_aim (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .frame_start    (scaler_video.vs),
    .pad            (pads.port1),
    .settings       (settings),
    .gun_aim        (gun_aim)
  );

  //////////////////////////////////////////////////
  // video path

  video_conditioner u_video_conditioner (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .core_video     (core_video),
    .settings       (settings),
    .scaler_video   (scaler_video)
  );

endmodule

`default_nettype wire

/* src/pad_router.sv */
// key bitmap to nes button mapping for all players
// port routing for swap, lightgun and multitap options

`default_nettype none

module pad_router (
  input  wire                             clk_74a,
  input  wire                             pll_core_locked,
  input  wire nes_frontend_pkg::key_bitmap_t [nes_frontend_pkg::NUM_PLAYERS-1:0] cont_key,
  input  wire nes_frontend_pkg::nes_settings_t settings,
  output nes_frontend_pkg::nes_ports_t    pads
);

  import nes_frontend_pkg::*;

  nes_buttons_t [NUM_PLAYERS-1:0] mapped;
  nes_ports_t                     routed;

  // per player bitmap extraction
  always_comb begin
    for (int i = 0; i < NUM_PLAYERS; i++) begin
      mapped[i].a      = cont_key[i][KEY_A];
      mapped[i].b      = cont_key[i][KEY_B];
      mapped[i].select = cont_key[i][KEY_SELECT];
      mapped[i].start  = cont_key[i][KEY_START];
      mapped[i].up     = cont_key[i][KEY_UP];
      mapped[i].down   = cont_key[i][KEY_DOWN];
      mapped[i].left   = cont_key[i][KEY_LEFT];
      mapped[i].right  = cont_key[i][KEY_RIGHT];
    end
  end

  //////////////////////////////////////////////////
  // port routing

  always_comb begin
    if (settings.swap_controllers) begin
      routed.port1 = mapped[1];
      routed.port2 = mapped[0];
    end else begin
      routed.port1 = mapped[0];
      routed.port2 = mapped[1];
    end

    // gun sits on port 2
    if (settings.lightgun_enabled) begin
      routed.port2 = '0;
    end

    routed.port3 = settings.multitap_enabled ? mapped[2] : '0;
    routed.port4 = settings.multitap_enabled ? mapped[3] : '0;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pads <= '0;
    end else begin
      pads <= routed;
    end
  end

endmodule

`default_nettype wire

/* src/settings_regs.sv */
// option registers loaded by bridge writes
// core reset hold counter started by a write to the reset address

`default_nettype none

module settings_regs (
  input  wire                              clk_74a,
  input  wire                              pll_core_locked,
  input  wire                              bridge_wr,
  input  wire nes_frontend_pkg::bridge_addr_t bridge_addr,
  input  wire nes_frontend_pkg::bridge_data_t bridge_wr_data,
  output nes_frontend_pkg::nes_settings_t  settings,
  output logic                             external_reset
);

  import nes_frontend_pkg::*;

  logic [RESET_CNT_W-1:0] hold_cnt;

  //////////////////////////////////////////////////
  // option registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        ADDR_HIDE_OVERSCAN: begin
          settings.hide_overscan <= bridge_wr_data[0];
        end
        ADDR_MASK_EDGES: begin
          settings.mask_vid_edges <= bridge_wr_data[1:0];
        end
        ADDR_EXTRA_SPRITES: begin
          settings.allow_extra_sprites <= bridge_wr_data[0];
        end
        ADDR_PALETTE: begin
          settings.selected_palette <= bridge_wr_data[2:0];
        end
        ADDR_MULTITAP: begin
          settings.multitap_enabled <= bridge_wr_data[0];
        end
        ADDR_LIGHTGUN: begin
          settings.lightgun_enabled <= bridge_wr_data[0];
        end
        ADDR_AIM_SPEED: begin
          settings.aim_speed <= bridge_wr_data[7:0];
        end
        ADDR_SWAP: begin
          settings.swap_controllers <= bridge_wr_data[0];
        end
        default: begin
          // unmapped address, nothing to store
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // reset hold

  // a new reset write restarts the full hold
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt <= '0;
    end else if (bridge_wr && bridge_addr == ADDR_RESET) begin
      hold_cnt <= RESET_CNT_W'(RESET_HOLD_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign external_reset = (hold_cnt != '0);

endmodule

`default_nettype wire

/* src/video_conditioner.sv */
// scaler timing from core blanking and syncs
// data enable, slot word after each active line
// single cycle vsync and delayed single cycle hsync

`default_nettype none

module video_conditioner (
  input  wire                              clk_74a,
  input  wire                              pll_core_locked,
  input  wire nes_frontend_pkg::core_video_t   core_video,
  input  wire nes_frontend_pkg::nes_settings_t settings,
  output nes_frontend_pkg::scaler_video_t  scaler_video
);

  import nes_frontend_pkg::*;

  logic                de;
  logic                de_prev;
  logic                hs_prev;
  logic                vs_prev;
  logic [HS_CNT_W-1:0] hs_delay;
  rgb_t                slot_word;

  assign de = ~(core_video.h_blank | core_video.v_blank);

  // slot word tells the scaler about overscan
  always_comb begin
    slot_word                    = '0;
    slot_word[SLOT_OVERSCAN_BIT] = settings.hide_overscan;
  end

  //////////////////////////////////////////////////
  // data enable and pixel data

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      scaler_video.de  <= 1'b0;
      scaler_video.rgb <= '0;
      de_prev          <= 1'b0;
    end else begin
      scaler_video.de <= de;
      de_prev         <= de;
      if (de) begin
        scaler_video.rgb <= core_video.rgb;
      end else if (de_prev) begin
        // first blank cycle after the line
        scaler_video.rgb <= slot_word;
      end else begin
        scaler_video.rgb <= '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // sync shaping

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      scaler_video.hs <= 1'b0;
      scaler_video.vs <= 1'b0;
      hs_prev         <= 1'b0;
      vs_prev         <= 1'b0;
      hs_delay        <= '0;
    end else begin
      hs_prev         <= core_video.hs;
      vs_prev         <= core_video.vs;
      scaler_video.vs <= core_video.vs & ~vs_prev;
      scaler_video.hs <= (hs_delay == HS_CNT_W'(1));

      // rising hs edge arms the delay
      if (core_video.hs && !hs_prev) begin
        hs_delay <= HS_CNT_W'(HS_DELAY_CYCLES);
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/nes_frontend_props.sv */
// concurrent assertions for the nes front end
// single cycle sync pulses and external reset low while in reset

`default_nettype none

module nes_frontend_props (
  input wire                                  clk_74a,
  input wire                                  pll_core_locked,
  input wire nes_frontend_pkg::scaler_video_t scaler_video,
  input wire                                  external_reset
);

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////////////
  // sync pulse widths

  property vs_single_cycle;
    @(posedge clk_74a) disable iff (!pll_core_locked)
      scaler_video.vs |=> !scaler_video.vs;
  endproperty

  property hs_single_cycle;
    @(posedge clk_74a) disable iff (!pll_core_locked)
      scaler_video.hs |=> !scaler_video.hs;
  endproperty

  // core reset output stays quiet while the front end itself is in reset
  property ext_reset_low_in_reset;
    @(posedge clk_74a) !pll_core_locked |-> !external_reset;
  endproperty

  a_vs_single_cycle: assert property (vs_single_cycle)
    else $error("video vs was high on two consecutive cycles");

  a_hs_single_cycle: assert property (hs_single_cycle)
    else $error("video hs was high on two consecutive cycles");

  a_ext_reset_low: assert property (ext_reset_low_in_reset)
    else $error("external reset was high while the front end was in reset");

endmodule

`default_nettype wire

/* testbench/tb_nes_frontend.sv */
// testbench for the nes front end
// directed tests for settings, reset hold, pad routing, video and lightgun aim
// compare tasks per result type, watchdog and final report

`default_nettype none

module tb_nes_frontend;

  timeunit 1ns;
  timeprecision 1ps;

  import nes_frontend_pkg::*;

  localparam int CLK_PERIOD = 10;
  // cycle budget of each test, summed for the watchdog
  localparam int TEST_CYCLES = 10 + 20 + (2 * RESET_HOLD_CYCLES + 30) + 70 + 40 + 30 + 50;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;

  logic                          clk_74a;
  logic                          pll_core_locked;
  logic                          bridge_wr;
  bridge_addr_t                  bridge_addr;
  bridge_data_t                  bridge_wr_data;
  key_bitmap_t [NUM_PLAYERS-1:0] cont_key;
  core_video_t                   core_video;
  nes_settings_t                 settings;
  logic                          external_reset;
  nes_ports_t                    pads;
  gun_aim_t                      gun_aim;
  scaler_video_t                 scaler_video;

  int error_count;

  nes_frontend_top UUT (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .cont_key       (cont_key),
    .core_video     (core_video),
    .settings       (settings),
    .external_reset (external_reset),
    .pads           (pads),
    .gun_aim        (gun_aim),
    .scaler_video   (scaler_video)
  );

  bind nes_frontend_top nes_frontend_props u_props (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .scaler_video   (scaler_video),
    .external_reset (external_reset)
  );

  always #(CLK_PERIOD / 2) clk_74a = ~clk_74a;

  //////////////////////////////////////////////////
  // compare tasks

  task automatic check_settings(input string name, input nes_settings_t exp,
                                input nes_settings_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_ports(input string name, input nes_ports_t exp, input nes_ports_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_aim(input string name, input gun_aim_t exp, input gun_aim_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_video(input string name, input scaler_video_t exp,
                             input scaler_video_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      error_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus helpers

  // inputs change 1 ns after the edge, outputs are read there too
  task automatic next_cycle();
    @(posedge clk_74a);
    #1;
  endtask

  task automatic write_reg(input bridge_addr_t addr, input bridge_data_t data);
    bridge_wr      = 1'b1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    next_cycle();
    bridge_wr      = 1'b0;
  endtask

  task automatic produce_frame();
    core_video.vs = 1'b1;
    next_cycle();
    core_video.vs = 1'b0;
    next_cycle();
  endtask

  // nes shift order, a in bit 0 up to right in bit 7
  function automatic nes_buttons_t map_keys(input key_bitmap_t k);
    return {k[KEY_RIGHT], k[KEY_LEFT], k[KEY_DOWN], k[KEY_UP],
            k[KEY_START], k[KEY_SELECT], k[KEY_B], k[KEY_A]};
  endfunction

  function automatic nes_ports_t route_pads(input key_bitmap_t [NUM_PLAYERS-1:0] keys,
                                            input logic swap, input logic multitap,
                                            input logic gun);
    nes_ports_t p;
    p.port1 = swap ? map_keys(keys[1]) : map_keys(keys[0]);
    p.port2 = swap ? map_keys(keys[0]) : map_keys(keys[1]);
    if (gun) begin
      p.port2 = 8'h00;
    end
    p.port3 = multitap ? map_keys(keys[2]) : 8'h00;
    p.port4 = multitap ? map_keys(keys[3]) : 8'h00;
    return p;
  endfunction

  //////////////////////////////////////////////////
  // directed tests

  task automatic run_settings_test();
    bridge_addr_t  opt_addr [8];
    bridge_data_t  data;
    nes_settings_t exp;
    opt_addr[0] = ADDR_HIDE_OVERSCAN;
    opt_addr[1] = ADDR_MASK_EDGES;
    opt_addr[2] = ADDR_EXTRA_SPRITES;
    opt_addr[3] = ADDR_PALETTE;
    opt_addr[4] = ADDR_MULTITAP;
    opt_addr[5] = ADDR_LIGHTGUN;
    opt_addr[6] = ADDR_AIM_SPEED;
    opt_addr[7] = ADDR_SWAP;
    exp = '0;
    for (int i = 0; i < 8; i++) begin
      data = $urandom;
      write_reg(opt_addr[i], data);
      case (i)
        0: exp.hide_overscan       = data[0];
        1: exp.mask_vid_edges      = data[1:0];
        2: exp.allow_extra_sprites = data[0];
        3: exp.selected_palette    = data[2:0];
        4: exp.multitap_enabled    = data[0];
        5: exp.lightgun_enabled    = data[0];
        6: exp.aim_speed           = data[7:0];
        default: exp.swap_controllers = data[0];
      endcase
      check_settings($sformatf("settings_write_%0d", i), exp, settings);
    end
    data = $urandom;
    write_reg(32'h400, data);
    check_settings("settings_unused_addr", exp, settings);
  endtask

  task automatic run_reset_hold_test();
    write_reg(ADDR_RESET, $urandom);
    for (int i = 0; i < RESET_HOLD_CYCLES; i++) begin
      check_bit("reset_hold", 1'b1, external_reset);
      next_cycle();
    end
    check_bit("reset_hold_end", 1'b0, external_reset);

    // second write part way through restarts the hold
    write_reg(ADDR_RESET, $urandom);
    for (int i = 0; i < 20; i++) begin
      check_bit("reset_hold_first", 1'b1, external_reset);
      next_cycle();
    end
    write_reg(ADDR_RESET, $urandom);
    for (int i = 0; i < RESET_HOLD_CYCLES; i++) begin
      check_bit("reset_hold_restart", 1'b1, external_reset);
      next_cycle();
    end
    check_bit("reset_hold_restart_end", 1'b0, external_reset);
  endtask

  task automatic run_pad_test();
    logic swap;
    logic multitap;
    logic gun;
    for (int c = 0; c < 8; c++) begin
      swap     = c[0];
      multitap = c[1];
      gun      = c[2];
      write_reg(ADDR_SWAP, bridge_data_t'(swap));
      write_reg(ADDR_MULTITAP, bridge_data_t'(multitap));
      write_reg(ADDR_LIGHTGUN, bridge_data_t'(gun));
      for (int n = 0; n < 4; n++) begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
          cont_key[p] = key_bitmap_t'($urandom);
        end
        next_cycle();
        check_ports($sformatf("pad_routing_%0d", c),
                    route_pads(cont_key, swap, multitap, gun), pads);
      end
    end
    write_reg(ADDR_LIGHTGUN, 32'd0);
    cont_key = '0;
  endtask

  task automatic drive_video_line(input string name, input logic overscan,
                                  input logic use_vblank);
    scaler_video_t exp;
    rgb_t          slot;
    write_reg(ADDR_HIDE_OVERSCAN, bridge_data_t'(overscan));
    slot                    = '0;
    slot[SLOT_OVERSCAN_BIT] = overscan;
    for (int i = 0; i < 8; i++) begin
      core_video     = '0;
      core_video.rgb = rgb_t'($urandom);
      next_cycle();
      exp     = '0;
      exp.de  = 1'b1;
      exp.rgb = core_video.rgb;
      check_video(name, exp, scaler_video);
    end
    for (int i = 0; i < 6; i++) begin
      core_video         = '0;
      core_video.h_blank = !use_vblank;
      core_video.v_blank = use_vblank;
      // blanked samples still carry pixel noise
      core_video.rgb     = rgb_t'($urandom);
      next_cycle();
      exp = '0;
      if (i == 0) begin
        exp.rgb = slot;
      end
      check_video(name, exp, scaler_video);
    end
  endtask

  task automatic run_sync_test();
    scaler_video_t exp;
    core_video         = '0;
    core_video.h_blank = 1'b1;
    core_video.v_blank = 1'b1;
    core_video.vs      = 1'b1;
    next_cycle();
    exp    = '0;
    exp.vs = 1'b1;
    check_video("sync_vs_pulse", exp, scaler_video);
    next_cycle();
    exp = '0;
    check_video("sync_vs_held", exp, scaler_video);
    core_video.vs = 1'b0;
    next_cycle();
    check_video("sync_vs_low", exp, scaler_video);

    // hs stays high, only its rising edge arms the delay
    core_video.hs = 1'b1;
    next_cycle();
    check_video("sync_hs_capture", exp, scaler_video);
    for (int k = 1; k <= HS_DELAY_CYCLES; k++) begin
      next_cycle();
      exp    = '0;
      exp.hs = (k == HS_DELAY_CYCLES);
      check_video("sync_hs_delay", exp, scaler_video);
    end
    core_video.hs = 1'b0;
    next_cycle();
    exp = '0;
    check_video("sync_hs_after", exp, scaler_video);
  endtask

  task automatic run_aim_test();
    aim_speed_t  speed;
    gun_aim_t    exp;
    key_bitmap_t k;
    int          ex;
    int          ey;
    speed = 8'd40;
    write_reg(ADDR_SWAP, 32'd0);
    write_reg(ADDR_MULTITAP, 32'd0);
    write_reg(ADDR_AIM_SPEED, bridge_data_t'(speed));
    write_reg(ADDR_LIGHTGUN, 32'd1);
    ex    = AIM_CENTER;
    ey    = AIM_CENTER;
    exp.x = aim_coord_t'(ex);
    exp.y = aim_coord_t'(ey);
    check_aim("aim_start", exp, gun_aim);

    k             = '0;
    k[KEY_RIGHT]  = 1'b1;
    k[KEY_DOWN]   = 1'b1;
    cont_key      = '0;
    cont_key[0]   = k;
    next_cycle();
    for (int f = 0; f < 5; f++) begin
      produce_frame();
      ex    = (ex + speed > 255) ? 255 : ex + speed;
      ey    = (ey + speed > 255) ? 255 : ey + speed;
      exp.x = aim_coord_t'(ex);
      exp.y = aim_coord_t'(ey);
      check_aim("aim_right_down", exp, gun_aim);
    end

    k            = '0;
    k[KEY_LEFT]  = 1'b1;
    k[KEY_UP]    = 1'b1;
    cont_key[0]  = k;
    next_cycle();
    for (int f = 0; f < 8; f++) begin
      produce_frame();
      ex    = (ex < speed) ? 0 : ex - speed;
      ey    = (ey < speed) ? 0 : ey - speed;
      exp.x = aim_coord_t'(ex);
      exp.y = aim_coord_t'(ey);
      check_aim("aim_left_up", exp, gun_aim);
    end

    // gun off, position must not move
    write_reg(ADDR_LIGHTGUN, 32'd0);
    k            = '0;
    k[KEY_RIGHT] = 1'b1;
    k[KEY_DOWN]  = 1'b1;
    cont_key[0]  = k;
    next_cycle();
    produce_frame();
    produce_frame();
    check_aim("aim_disabled", exp, gun_aim);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog

  initial begin
    clk_74a         = 1'b0;
    pll_core_locked = 1'b0;
    bridge_wr       = 1'b0;
    bridge_addr     = '0;
    bridge_wr_data  = '0;
    error_count     = 0;
    void'($urandom(32'h336b_eae9));
    // live keys and pixels during reset, outputs must still read zero
    for (int p = 0; p < NUM_PLAYERS; p++) begin
      cont_key[p] = key_bitmap_t'($urandom);
    end
    core_video     = '0;
    core_video.rgb = rgb_t'($urandom);

    repeat (3) @(posedge clk_74a);
    #1;
    check_settings("reset_settings", '0, settings);
    check_bit("reset_external", 1'b0, external_reset);
    check_ports("reset_pads", '0, pads);
    check_video("reset_video", '0, scaler_video);
    check_aim("reset_aim", {AIM_CENTER, AIM_CENTER}, gun_aim);
    pll_core_locked = 1'b1;
    next_cycle();

    run_settings_test();
    run_reset_hold_test();
    run_pad_test();
    drive_video_line("video_line_hblank", 1'b1, 1'b0);
    drive_video_line("video_line_vblank", 1'b0, 1'b1);
    run_sync_test();
    run_aim_test();
    next_cycle();

    $display("error count: %0d", error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished, run stopped");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
